// ==== hw/isa_pkg.sv ====
`default_nettype none

// Architectural view of the machine: register file size and instruction format
package isa_pkg;

	localparam int num_gen_reg  = 16;                   // Architectural registers
	localparam int gen_reg_bits = $clog2(num_gen_reg);  // Index width
	localparam int opcode_bits  = 4;

	typedef logic [gen_reg_bits-1:0] gen_reg_t;         // Architectural register index

	// Legal opcodes
	// Codes not listed here are illegal and behave like a nop
	typedef enum logic [opcode_bits-1:0] {
		op_nop    = 4'h0,  // Reads nothing, writes nothing
		op_alu    = 4'h1,  // Reads a and b, writes dest
		op_alui   = 4'h2,  // Reads a, writes dest
		op_load   = 4'h3,  // Reads a, writes dest
		op_store  = 4'h4,  // Reads a and b
		op_branch = 4'h5   // Reads a and b
	} opcode_t;

	// One 16-bit instruction word
	typedef struct packed {
		logic [opcode_bits-1:0] opcode;  // Raw code, may fall outside opcode_t
		gen_reg_t               dest;    // [11:8]
		gen_reg_t               src_a;   // [7:4]
		gen_reg_t               src_b;   // [3:0]
	} inst_t;

endpackage

`default_nettype wire

// ==== hw/rename_pkg.sv ====
`default_nettype none

// Physical side of rename: tag format, map rows, queue sizes
package rename_pkg;

	localparam int num_phys_reg = 32;
	localparam int phys_bits    = $clog2(num_phys_reg);

	// Registers not mapped at reset start out in the free list
	localparam int free_depth     = num_phys_reg - isa_pkg::num_gen_reg;
	localparam int free_ptr_bits  = $clog2(free_depth);
	localparam int free_cnt_bits  = free_ptr_bits + 1;  // Count reaches free_depth

	localparam int cq_depth      = 8;  // Completion queue entries
	localparam int cq_ptr_bits   = $clog2(cq_depth);
	localparam int cq_cnt_bits   = cq_ptr_bits + 1;

	typedef logic [phys_bits-1:0] phys_idx_t;  // Physical register index

	// Ready bit sits above the index
	// Tags match on idx alone, ready is ignored in compares
	typedef struct packed {
		logic      ready;
		phys_idx_t idx;
	} phys_tag_t;

	typedef struct packed {
		phys_tag_t phys_tag;  // Current mapping of one architectural register
	} map_row_t;

endpackage

`default_nettype wire

// ==== hw/dispatch_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One decoded instruction that has been accepted for rename this cycle
interface dispatch_if;

	logic             fire;         // Dispatches at the coming edge
	logic             writes_dest;  // Needs a new physical register
	isa_pkg::gen_reg_t dest;
	isa_pkg::gen_reg_t src_a;
	isa_pkg::gen_reg_t src_b;

	modport decoder (
		output fire, writes_dest, dest, src_a, src_b
	);

	modport rename (
		input fire, writes_dest, dest, src_a, src_b
	);

endinterface

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  isa_pkg::inst_t inst,
	input  logic           inst_valid,
	input  logic           free_empty,  // Free list has no register to hand out
	output logic           stall,
	output logic           illegal,
	dispatch_if.decoder    disp
);

	isa_pkg::opcode_t opcode;
	logic             legal;
	logic             writes;

	// Classify the opcode
	always_comb begin
		opcode = isa_pkg::opcode_t'(inst.opcode);
		legal  = 1'b1;
		writes = 1'b0;
		case (opcode)
			isa_pkg::op_alu,
			isa_pkg::op_alui,
			isa_pkg::op_load: begin
				writes = 1'b1;  // Producers of a register
			end
			isa_pkg::op_nop,
			isa_pkg::op_store,
			isa_pkg::op_branch: begin
				writes = 1'b0;
			end
			default: begin
				legal = 1'b0;  // Unknown code, runs as a nop
			end
		endcase
	end

	// Only a writer can be held up, and only when no register is free
	assign stall   = inst_valid & writes & free_empty;
	assign illegal = inst_valid & ~legal;

	// Dispatch bundle
	assign disp.fire        = inst_valid & ~stall;
	assign disp.writes_dest = writes;
	assign disp.dest        = inst.dest;
	assign disp.src_a       = inst.src_a;
	assign disp.src_b       = inst.src_b;

endmodule

`default_nettype wire

// ==== hw/map_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_table (
	input  logic                  clock,
	input  logic                  reset,
	dispatch_if.rename            disp,
	input  rename_pkg::phys_idx_t new_idx,    // Free list head
	input  rename_pkg::phys_idx_t cdb_idx,
	input  logic                  cdb_valid,
	output rename_pkg::phys_tag_t t1,         // Source a
	output rename_pkg::phys_tag_t t2,         // Source b
	output rename_pkg::phys_tag_t t_old       // Previous mapping of dest
);

	rename_pkg::map_row_t [isa_pkg::num_gen_reg-1:0] map_q;
	rename_pkg::map_row_t [isa_pkg::num_gen_reg-1:0] map_d;

	logic do_rename;
	logic new_idx_mapped;  // Head of free list already appears in some row

	assign do_rename = disp.fire & disp.writes_dest;

	// Lookups read registered state only, no bus bypass
	assign t1    = map_q[disp.src_a].phys_tag;
	assign t2    = map_q[disp.src_b].phys_tag;
	assign t_old = map_q[disp.dest].phys_tag;

	always_comb begin
		map_d = map_q;
		// Bus first
		// Every row holding the broadcast index becomes ready
		if (cdb_valid) begin
			for (int i = 0; i < isa_pkg::num_gen_reg; i++) begin
				if (map_q[i].phys_tag.idx == cdb_idx) begin
					map_d[i].phys_tag.ready = 1'b1;
				end
			end
		end
		// Rename second, so it overrides a same-cycle ready set
		if (do_rename) begin
			map_d[disp.dest].phys_tag.idx   = new_idx;
			map_d[disp.dest].phys_tag.ready = 1'b0;  // Value not produced yet
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// Identity map, all values available
			for (int i = 0; i < isa_pkg::num_gen_reg; i++) begin
				map_q[i].phys_tag.idx   <= rename_pkg::phys_idx_t'(i);
				map_q[i].phys_tag.ready <= 1'b1;
			end
		end else begin
			map_q <= map_d;
		end
	end

	always_comb begin
		new_idx_mapped = 1'b0;
		for (int i = 0; i < isa_pkg::num_gen_reg; i++) begin
			if (map_q[i].phys_tag.idx == new_idx) begin
				new_idx_mapped = 1'b1;
			end
		end
	end

	// Free list and retire must never hand back a register that is still live
	a_rename_unique: assert property (
		@(posedge clock) disable iff (reset)
		do_rename |-> !new_idx_mapped
	) else $error("map_table: new tag %0d is already mapped", new_idx);

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ns
`default_nettype none

module free_list (
	input  logic                  clock,
	input  logic                  reset,
	dispatch_if.rename            disp,
	input  rename_pkg::phys_idx_t retire_idx,    // Old register released at retire
	input  logic                  retire_valid,
	output rename_pkg::phys_idx_t head_idx,      // Next register to rename into
	output logic                  empty
);

	rename_pkg::phys_idx_t mem [rename_pkg::free_depth];

	logic [rename_pkg::free_ptr_bits-1:0] rd_ptr;
	logic [rename_pkg::free_ptr_bits-1:0] wr_ptr;
	logic [rename_pkg::free_cnt_bits-1:0] count;

	logic pop;
	logic push;
	logic full;

	assign pop  = disp.fire & disp.writes_dest;
	assign push = retire_valid;

	assign head_idx = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == rename_pkg::free_cnt_bits'(rename_pkg::free_depth));

	// Storage
	// Reset fills it with the registers left over after the identity map
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_pkg::free_depth; i++) begin
				mem[i] <= rename_pkg::phys_idx_t'(isa_pkg::num_gen_reg + i);
			end
		end else if (push) begin
			mem[wr_ptr] <= retire_idx;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;  // Full at reset, so write meets read
			count  <= rename_pkg::free_cnt_bits'(rename_pkg::free_depth);
		end else begin
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	// Decoder must stall writers while empty
	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (reset)
		pop |-> !empty
	) else $error("free_list: pop while empty");

	// A retire can only return a register that a rename took out
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		push |-> !full
	) else $error("free_list: push of %0d while full", retire_idx);

endmodule

`default_nettype wire

// ==== hw/completion_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module completion_queue (
	input  logic                  clock,
	input  logic                  reset,
	input  rename_pkg::phys_idx_t done_tag_0,
	input  rename_pkg::phys_idx_t done_tag_1,
	input  logic                  done_valid_0,  // Slot 0 goes in ahead of slot 1
	input  logic                  done_valid_1,
	output rename_pkg::phys_idx_t cdb_idx,
	output logic                  cdb_valid,
	output logic                  queue_full     // Fewer than two slots left
);

	rename_pkg::phys_idx_t mem [rename_pkg::cq_depth];

	logic [rename_pkg::cq_ptr_bits-1:0] rd_ptr;
	logic [rename_pkg::cq_ptr_bits-1:0] wr_ptr;
	logic [rename_pkg::cq_ptr_bits-1:0] slot_1;   // Where done_tag_1 lands
	logic [rename_pkg::cq_cnt_bits-1:0] count;
	logic [rename_pkg::cq_cnt_bits-1:0] num_in;   // 0, 1 or 2 writes this edge
	logic                               pop;

	// Compaction
	// A lone done_1 takes the tail slot, otherwise it sits behind done_0
	assign slot_1 = wr_ptr + rename_pkg::cq_ptr_bits'(done_valid_0);
	assign num_in = rename_pkg::cq_cnt_bits'(done_valid_0)
		+ rename_pkg::cq_cnt_bits'(done_valid_1);

	// Head is broadcast whenever anything is queued
	assign cdb_idx    = mem[rd_ptr];
	assign cdb_valid  = (count != '0);
	assign pop        = cdb_valid;  // Bus takes the head every cycle
	assign queue_full = (count >= rename_pkg::cq_cnt_bits'(rename_pkg::cq_depth - 1));

	// Payload storage
	always_ff @(posedge clock) begin
		if (done_valid_0) begin
			mem[wr_ptr] <= done_tag_0;
		end
		if (done_valid_1) begin
			mem[slot_1] <= done_tag_1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + rename_pkg::cq_ptr_bits'(num_in);  // Wraps at depth
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + num_in - rename_pkg::cq_cnt_bits'(pop);
		end
	end

	// Execution side must hold off while full, nothing here pushes back
	a_no_done_full: assert property (
		@(posedge clock) disable iff (reset)
		queue_full |-> !(done_valid_0 || done_valid_1)
	) else $error("completion_queue: done tag while queue_full");

endmodule

`default_nettype wire

// ==== hw/rename_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_top (
	input  logic                  clock,
	input  logic                  reset,
	// Instruction in
	input  isa_pkg::inst_t        inst,
	input  logic                  inst_valid,
	// Done tags from execution
	input  rename_pkg::phys_idx_t done_tag_0,
	input  logic                  done_valid_0,
	input  rename_pkg::phys_idx_t done_tag_1,
	input  logic                  done_valid_1,
	// Retire
	input  rename_pkg::phys_idx_t retire_idx,
	input  logic                  retire_valid,
	// Rename results
	output rename_pkg::phys_tag_t t1,
	output rename_pkg::phys_tag_t t2,
	output rename_pkg::phys_tag_t t_old,
	output rename_pkg::phys_tag_t t_new,
	output logic                  stall,
	output logic                  illegal,
	// Common data bus
	output rename_pkg::phys_idx_t cdb_idx,
	output logic                  cdb_valid,
	output logic                  queue_full
);

	rename_pkg::phys_idx_t head_idx;
	logic                  free_empty;

	dispatch_if disp ();

	// New register is never ready when handed out
	assign t_new = '{ready: 1'b0, idx: head_idx};

	inst_decoder inst_decoder_i (
		.inst       (inst),
		.inst_valid (inst_valid),
		.free_empty (free_empty),
		.stall      (stall),
		.illegal    (illegal),
		.disp       (disp.decoder)
	);

	map_table map_table_i (
		.clock     (clock),
		.reset     (reset),
		.disp      (disp.rename),
		.new_idx   (head_idx),
		.cdb_idx   (cdb_idx),    // Bus loops back to set ready bits
		.cdb_valid (cdb_valid),
		.t1        (t1),
		.t2        (t2),
		.t_old     (t_old)
	);

	free_list free_list_i (
		.clock        (clock),
		.reset        (reset),
		.disp         (disp.rename),
		.retire_idx   (retire_idx),
		.retire_valid (retire_valid),
		.head_idx     (head_idx),
		.empty        (free_empty)
	);

	completion_queue completion_queue_i (
		.clock        (clock),
		.reset        (reset),
		.done_tag_0   (done_tag_0),
		.done_tag_1   (done_tag_1),
		.done_valid_0 (done_valid_0),
		.done_valid_1 (done_valid_1),
		.cdb_idx      (cdb_idx),
		.cdb_valid    (cdb_valid),
		.queue_full   (queue_full)
	);

endmodule

`default_nettype wire

// ==== verif/rename_model.svh ====
`ifndef rename_model_svh
`define rename_model_svh

// Reference model of the rename block
// Advanced once per rising edge from the inputs driven in that cycle

localparam int m_arch_regs = 16;  // Architectural registers
localparam int m_cq_full   = 7;   // Queue level that reports full

int m_map_idx [];       // Physical index per architectural register
int m_map_rdy [];       // Ready bit per architectural register
int m_free [$];         // Free registers, head first
int m_cq [$];           // Completion queue, head first
int m_retirable [$];    // Old tags freed by renames, oldest first

// Opcodes 1 to 3 produce a register
function automatic bit writes_reg(input logic [3:0] op);
	return (op == 4'h1) || (op == 4'h2) || (op == 4'h3);
endfunction

function automatic bit legal_opcode(input logic [3:0] op);
	return op <= 4'h5;  // Codes above branch are illegal
endfunction

// Writer with nothing free has to wait
function automatic bit expect_stall(input logic [15:0] word, input logic valid);
	return valid && writes_reg(word[15:12]) && (m_free.size() == 0);
endfunction

// Ready bit above a 5-bit index
function automatic logic [31:0] make_tag(input int rdy, input int idx);
	return {26'b0, rdy[0], idx[4:0]};
endfunction

task automatic reset_model();
	m_map_idx = new[m_arch_regs];
	m_map_rdy = new[m_arch_regs];
	m_free.delete();
	m_cq.delete();
	m_retirable.delete();
	for (int i = 0; i < m_arch_regs; i++) begin
		m_map_idx[i] = i;                  // Identity map
		m_map_rdy[i] = 1;
		m_free.push_back(m_arch_regs + i);  // 16 to 31 in order
	end
endtask

// One rising edge
task automatic advance_model(input logic [15:0] word, input logic valid,
		input logic d0v, input logic [4:0] d0, input logic d1v, input logic [4:0] d1,
		input logic rv);
	int         bus;
	bit         fire;
	logic [3:0] dest;
	dest = word[11:8];
	fire = valid && !expect_stall(word, valid);
	if (m_cq.size() > 0) begin
		bus = m_cq.pop_front();  // Head leaves on the bus
		for (int i = 0; i < m_arch_regs; i++) begin
			if (m_map_idx[i] == bus) begin
				m_map_rdy[i] = 1;
			end
		end
	end
	if (fire && writes_reg(word[15:12])) begin  // Rename after the bus, so it wins
		m_retirable.push_back(m_map_idx[dest]);
		m_map_idx[dest] = m_free.pop_front();
		m_map_rdy[dest] = 0;
	end
	if (rv) begin
		m_free.push_back(m_retirable.pop_front());  // Driven index was the oldest one
	end
	if (d0v) begin
		m_cq.push_back(int'(d0));  // Slot 0 goes first
	end
	if (d1v) begin
		m_cq.push_back(int'(d1));
	end
endtask

`endif

// ==== verif/tb_rename.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rename;

	localparam int period        = 100;
	localparam int reset_cycles  = 10;
	localparam int total_cycles  = reset_cycles + 16 + 200 + 300 + 200 + 40 + 150;
	localparam int margin_cycles = 100;

	logic        clock;
	logic        reset;
	logic [15:0] inst_word;
	logic        inst_valid;
	logic [4:0]  done_tag_0;
	logic        done_valid_0;
	logic [4:0]  done_tag_1;
	logic        done_valid_1;
	logic [4:0]  retire_idx;
	logic        retire_valid;
	logic [5:0]  t1;
	logic [5:0]  t2;
	logic [5:0]  t_old;
	logic [5:0]  t_new;
	logic        stall;
	logic        illegal;
	logic [4:0]  cdb_idx;
	logic        cdb_valid;
	logic        queue_full;

	int checks;
	int errors;
	int tests;
	int stall_seen;   // Cycles the model expected a stall
	int full_seen;    // Cycles the model expected queue_full
	int sweep;        // Source index walk for idle cycles
	bit held;         // Instruction stalled and goes out again

	`include "rename_model.svh"

	rename_top rename_top_i (
		.clock        (clock),
		.reset        (reset),
		.inst         (inst_word),
		.inst_valid   (inst_valid),
		.done_tag_0   (done_tag_0),
		.done_valid_0 (done_valid_0),
		.done_tag_1   (done_tag_1),
		.done_valid_1 (done_valid_1),
		.retire_idx   (retire_idx),
		.retire_valid (retire_valid),
		.t1           (t1),
		.t2           (t2),
		.t_old        (t_old),
		.t_new        (t_new),
		.stall        (stall),
		.illegal      (illegal),
		.cdb_idx      (cdb_idx),
		.cdb_valid    (cdb_valid),
		.queue_full   (queue_full)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin : watchdog
		#((total_cycles + margin_cycles) * period);
		$display("Timeout: the tests did not finish within %0d cycles",
			total_cycles + margin_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// Half the tags hit a live mapping so ready bits really change
	function automatic logic [4:0] pick_done_tag();
		logic [3:0] row;
		row = 4'($urandom_range(15));
		if ($urandom_range(1) == 1) begin
			return 5'(m_map_idx[row]);
		end
		return 5'($urandom);
	endfunction

	task automatic drive_random(input int p_valid, input bit any_op, input int p_retire,
			input int p_done);
		logic [3:0] op;
		bit         room;
		if (!held) begin  // Stalled instruction is held
			op = any_op ? 4'($urandom_range(15)) : 4'($urandom_range(3, 1));
			inst_word  = {op, 4'($urandom), 4'($urandom), 4'($urandom)};
			inst_valid = ($urandom_range(99) < p_valid);
			if (p_valid == 0) begin
				inst_word[7:0] = {4'(sweep), 4'(15 - sweep)};  // Walk every source
				sweep++;
			end
		end
		retire_valid = (m_retirable.size() > 0) && ($urandom_range(99) < p_retire);
		retire_idx   = retire_valid ? 5'(m_retirable[0]) : 5'($urandom);
		room         = (m_cq.size() < m_cq_full);  // Never send done tags while full
		done_valid_0 = room && ($urandom_range(99) < p_done);
		done_valid_1 = room && ($urandom_range(99) < p_done);
		done_tag_0   = pick_done_tag();
		done_tag_1   = pick_done_tag();
	endtask

	task automatic compare_outputs();
		logic [3:0] sa;
		logic [3:0] sb;
		logic [3:0] dst;
		bit         exp_stall;
		sa        = inst_word[7:4];
		sb        = inst_word[3:0];
		dst       = inst_word[11:8];
		exp_stall = expect_stall(inst_word, inst_valid);
		check_val("t1", make_tag(m_map_rdy[sa], m_map_idx[sa]), 32'(t1));
		check_val("t2", make_tag(m_map_rdy[sb], m_map_idx[sb]), 32'(t2));
		check_val("t_old", make_tag(m_map_rdy[dst], m_map_idx[dst]), 32'(t_old));
		if (m_free.size() > 0) begin
			check_val("t_new", make_tag(0, m_free[0]), 32'(t_new));  // Head, never ready
		end
		check_val("stall", 32'(exp_stall), 32'(stall));
		check_val("illegal", 32'(inst_valid && !legal_opcode(inst_word[15:12])), 32'(illegal));
		check_val("cdb_valid", 32'(m_cq.size() != 0), 32'(cdb_valid));
		if (m_cq.size() != 0) begin
			check_val("cdb_idx", 32'(m_cq[0]), 32'(cdb_idx));
		end
		check_val("queue_full", 32'(m_cq.size() >= m_cq_full), 32'(queue_full));
		held = exp_stall;  // Same word again next cycle
		if (exp_stall) begin
			stall_seen++;
		end
		if (m_cq.size() >= m_cq_full) begin
			full_seen++;
		end
	endtask

	// Drive on the falling edge, compare just before the rising edge
	task automatic step_cycle(input int p_valid, input bit any_op, input int p_retire,
			input int p_done);
		@(negedge clock);
		drive_random(p_valid, any_op, p_retire, p_done);
		#(period / 2 - 10);
		compare_outputs();
		@(posedge clock);
		advance_model(inst_word, inst_valid, done_valid_0, done_tag_0, done_valid_1,
			done_tag_1, retire_valid);
	endtask

	// need 1 expects a stall, need 2 expects queue_full
	task automatic run_test(input string name, input int cycles, input int p_valid,
			input bit any_op, input int p_retire, input int p_done, input int need);
		int errors_before;
		errors_before = errors;
		stall_seen    = 0;
		full_seen     = 0;
		for (int c = 0; c < cycles; c++) begin
			step_cycle(p_valid, any_op, p_retire, p_done);
		end
		if (need == 1 && stall_seen == 0) begin
			errors++;
			$display("Test %s never reached a stall", name);
		end
		if (need == 2 && full_seen == 0) begin
			errors++;
			$display("Test %s never filled the completion queue", name);
		end
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	initial begin
		void'($urandom(32));  // Seeds the generator for the whole run
		reset        = 1'b1;
		inst_word    = '0;
		inst_valid   = 1'b0;
		done_tag_0   = '0;
		done_valid_0 = 1'b0;
		done_tag_1   = '0;
		done_valid_1 = 1'b0;
		retire_idx   = '0;
		retire_valid = 1'b0;
		checks       = 0;
		errors       = 0;
		tests        = 0;
		sweep        = 0;
		held         = 1'b0;
		reset_model();
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		run_test("reset_state", 16, 0, 1'b1, 0, 0, 0);      // Idle, identity map
		run_test("decode", 200, 80, 1'b1, 30, 20, 0);       // All 16 codes
		run_test("rename_chain", 300, 90, 1'b0, 60, 20, 0); // Writers with retires
		run_test("ready_tracking", 200, 70, 1'b0, 50, 60, 0);
		run_test("stall", 40, 100, 1'b0, 0, 0, 1);          // Free list runs dry
		run_test("queue_flow", 150, 80, 1'b0, 50, 100, 2);  // Two-wide bursts
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/isa_pkg.sv
hw/rename_pkg.sv
hw/dispatch_if.sv
hw/inst_decoder.sv
hw/map_table.sv
hw/free_list.sv
hw/completion_queue.sv
hw/rename_top.sv
+incdir+verif
verif/tb_rename.sv

// ==== run.sh ====
#!/bin/sh
# Build the rename testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_rename -o sim_rename \
	&& ./obj_dir/sim_rename > sim.log 2>&1 \
	|| echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
